/* obj_consts.svh */
// sizes shared by the object line table blocks
// frame table is 256 objects of four words, line table is 128 tiles of three words
// each line entry is padded to four words, so one bank spans 512 addresses

`ifndef OBJ_CONSTS_SVH
`define OBJ_CONSTS_SVH

// frame table address width, 1024 words
`define OBJ_FRAME_AW 10

// tiles one line can hold
`define OBJ_LINE_TILES 128

// read address width of one line bank, entry index plus word select
`define OBJ_LINE_AW 9

// fill word for unused slots, also ends the fetch
`define OBJ_EMPTY 16'hffff

`endif

/* obj_pkg.sv */
// types shared by the object line table blocks
// the attribute word layout follows the object frame table format

`default_nettype none

package obj_pkg;

    // bit 7 carries nothing in this format
    typedef struct packed {
        logic [3:0] tile_m;   // extra tile rows
        logic [3:0] tile_n;   // extra tile columns
        logic       spare;
        logic       vflip;
        logic       hflip;
        logic [4:0] pal;
    } obj_attr_t;

    // raw view for storage and the repeat compare
    typedef union packed {
        logic [15:0] raw;
        obj_attr_t   f;
    } obj_attr_u;

endpackage

`default_nettype wire

/* obj_frame_ram.sv */
// object frame table, written by the host one word per cycle
// read data shows up one cycle after rd_addr
// a read of the word being written returns the old contents
// contents are undefined until the host loads them

`default_nettype none

`include "obj_consts.svh"

module obj_frame_ram (
    input  wire                     clk,
    input  wire [`OBJ_FRAME_AW-1:0] wr_addr,
    input  wire [15:0]              wr_data,
    input  wire                     wr_en,
    input  wire [`OBJ_FRAME_AW-1:0] rd_addr,
    output logic [15:0]             rd_data
);

    // four words per object, first object at the top address
    logic [15:0] mem [0:(1 << `OBJ_FRAME_AW) - 1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data; // host port
        end
        rd_data <= mem[rd_addr];     // builder port
    end

endmodule

`default_nettype wire

/* obj_zone_match.sv */
// vertical zone check of one object against the line being built
// rows are 16 lines tall, an object spans tile_m + 1 rows from obj_y
// line arithmetic is 9 bits, so tall objects wrap past line 511

`default_nettype none

module obj_zone_match
    import obj_pkg::*;
(
    input  wire obj_attr_u  attr,
    input  wire [7:0]       obj_y,
    input  wire [8:0]       vrender1,
    output logic            inzone,
    output logic [3:0]      m,
    output logic [3:0]      vsub
);

    logic [8:0]  ydiff;   // line offset from the object top
    logic [15:0] match;   // one bit per tile row

    always_comb begin
        ydiff = vrender1 - {1'b0, obj_y};
        // row r covers offsets 16r .. 16r+15, valid up to tile_m
        for (int r = 0; r < 16; r++) begin
            match[r] = (ydiff[8:4] == 5'(r)) && (4'(r) <= attr.f.tile_m);
        end
    end

    // winning row and pixel row inside the tile
    always_comb begin
        m = 4'd0;
        for (int r = 0; r < 16; r++) begin
            if (match[r]) begin
                m = 4'(r);
            end
        end
        inzone = |match;
        vsub   = ydiff[3:0] ^ {4{attr.f.vflip}}; // upside down under vflip
    end

endmodule

`default_nettype wire

/* obj_line_table.sv */
// line table builder for one video line, frame table read from the top address down
// vrender1 must stay steady from start until build_done rises
// bank vrender1[0] is written while bank ~vrender1[0] is read by the fetch
// each entry is three words, attr and vsub, tile code, tile x, padded to four

`default_nettype none

`include "obj_consts.svh"

module obj_line_table
    import obj_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire [8:0]                vrender1,
    input  wire                      start,
    output logic [`OBJ_FRAME_AW-1:0] frame_addr,
    input  wire [15:0]               frame_data,
    input  wire [`OBJ_LINE_AW-1:0]   line_addr,
    output logic [15:0]              line_data,
    output logic                     build_done
);

    localparam int CW = `OBJ_LINE_AW - 2; // entry index width
    localparam int BW = CW + 1;           // count width with headroom for the range check

    localparam logic [3:0] ST_IDLE  = 4'd0;
    localparam logic [3:0] ST_WAIT  = 4'd1;
    localparam logic [3:0] ST_ATTR  = 4'd2;
    localparam logic [3:0] ST_CODE  = 4'd3;
    localparam logic [3:0] ST_Y     = 4'd4;
    localparam logic [3:0] ST_X     = 4'd5;
    localparam logic [3:0] ST_CHECK = 4'd6;
    localparam logic [3:0] ST_W0    = 4'd7;
    localparam logic [3:0] ST_W1    = 4'd8;
    localparam logic [3:0] ST_W2    = 4'd9;
    localparam logic [3:0] ST_NEXT  = 4'd10;
    localparam logic [3:0] ST_F0    = 4'd11;
    localparam logic [3:0] ST_F1    = 4'd12;
    localparam logic [3:0] ST_F2    = 4'd13;

    logic [3:0]  state;
    logic [15:0] line_buf [0:(1 << (`OBJ_LINE_AW + 1)) - 1]; // two banks
    logic [BW-1:0] line_cnt;

    obj_attr_u   attr, last_attr;
    logic [15:0] code, last_code;
    logic [15:0] obj_y, last_y;
    logic [15:0] obj_x, last_x;
    logic        first;     // no previous object to compare against yet
    logic        last_obj;  // bottom of the frame table reached
    logic [3:0]  n;         // column being written
    logic [3:0]  npos;      // x slot of that column
    logic        repeated;

    logic        inzone;
    logic [3:0]  m, vsub, row;
    logic [15:0] code_mn;

    logic                    lb_we;
    logic [1:0]              lb_sub;
    logic [15:0]             lb_wdata;
    logic [`OBJ_LINE_AW:0]   lb_addr;

    obj_zone_match u_zone (
        .attr     (attr),
        .obj_y    (obj_y[7:0]),
        .vrender1 (vrender1),
        .inzone   (inzone),
        .m        (m),
        .vsub     (vsub)
    );

    assign repeated = (attr.raw == last_attr.raw) && (code == last_code) &&
                      (obj_y == last_y) && (obj_x == last_x);

    // rows count up in the code's second nibble, columns in the low nibble
    assign row     = attr.f.vflip ? attr.f.tile_m - m : m;
    assign code_mn = {code[15:8], code[7:4] + row, code[3:0] + n};

    always_comb begin
        lb_we    = 1'b1;
        lb_sub   = 2'd0;
        lb_wdata = `OBJ_EMPTY;
        case (state)
            ST_W0: lb_wdata = {4'd0, vsub, attr.raw[7:0]};
            ST_W1: begin
                lb_sub   = 2'd1;
                lb_wdata = code_mn;
            end
            ST_W2: begin
                lb_sub   = 2'd2;
                lb_wdata = obj_x + {8'd0, npos, 4'd0}; // 16 pixels per column
            end
            ST_F0: lb_sub = 2'd0;
            ST_F1: lb_sub = 2'd1;
            ST_F2: lb_sub = 2'd2;
            default: lb_we = 1'b0;
        endcase
    end

    assign lb_addr = {vrender1[0], line_cnt[CW-1:0], lb_sub};

    always_ff @(posedge clk) begin
        if (lb_we) begin
            line_buf[lb_addr] <= lb_wdata;
        end
        line_data <= line_buf[{~vrender1[0], line_addr}]; // bank being drawn
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            frame_addr <= '1;
            build_done <= 1'b0;
            first      <= 1'b1;
            last_obj   <= 1'b0;
            line_cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        frame_addr <= '1;
                        line_cnt   <= '0;
                        first      <= 1'b1;
                        last_obj   <= 1'b0;
                        build_done <= 1'b0;
                        state      <= ST_WAIT;
                    end
                end
                ST_WAIT: begin // RAM latency
                    frame_addr <= frame_addr - 1'b1;
                    state      <= ST_ATTR;
                end
                ST_ATTR: begin
                    last_attr  <= attr;
                    attr.raw   <= frame_data;
                    frame_addr <= frame_addr - 1'b1;
                    state      <= ST_CODE;
                end
                ST_CODE: begin
                    last_code  <= code;
                    code       <= frame_data;
                    frame_addr <= frame_addr - 1'b1;
                    state      <= ST_Y;
                end
                ST_Y: begin // x word already addressed
                    last_y <= obj_y;
                    obj_y  <= frame_data;
                    state  <= ST_X;
                end
                ST_X: begin
                    last_x     <= obj_x;
                    obj_x      <= frame_data;
                    last_obj   <= (frame_addr[`OBJ_FRAME_AW-1:2] == '0);
                    frame_addr <= frame_addr - 1'b1; // attr of the next object
                    state      <= ST_CHECK;
                end
                ST_CHECK: begin
                    first <= 1'b0;
                    if (!inzone || (repeated && !first)) begin
                        state <= last_obj ? ST_F0 : ST_WAIT;
                    end else begin
                        n     <= 4'd0;
                        npos  <= attr.f.hflip ? attr.f.tile_n : 4'd0;
                        state <= ST_W0;
                    end
                end
                ST_W0: state <= ST_W1;
                ST_W1: state <= ST_W2;
                ST_W2: state <= ST_NEXT;
                ST_NEXT: begin
                    if (line_cnt == BW'(`OBJ_LINE_TILES - 1)) begin
                        build_done <= 1'b1; // line full, no fill needed
                        state      <= ST_IDLE;
                    end else begin
                        line_cnt <= line_cnt + 1'b1;
                        if (n == attr.f.tile_n) begin
                            state <= last_obj ? ST_F0 : ST_WAIT;
                        end else begin
                            n     <= n + 4'd1;
                            npos  <= attr.f.hflip ? npos - 4'd1 : npos + 4'd1;
                            state <= ST_W0;
                        end
                    end
                end
                ST_F0: state <= ST_F1;
                ST_F1: state <= ST_F2;
                ST_F2: begin
                    if (line_cnt == BW'(`OBJ_LINE_TILES - 1)) begin
                        build_done <= 1'b1;
                        state      <= ST_IDLE;
                    end else begin
                        line_cnt <= line_cnt + 1'b1;
                        state    <= ST_F0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        line_cnt < BW'(`OBJ_LINE_TILES))
        else $error("line table: tile count past the last slot");

    a_done_idle: assert property (@(posedge clk) disable iff (rst)
        (state != ST_IDLE) |-> !build_done)
        else $error("line table: build_done high during a build");

endmodule

`default_nettype wire

/* obj_line_fetch.sv */
// walks the finished line bank and emits one descriptor per tile entry
// four cycles per entry, stops at the first empty word 0 or after the last slot
// the host must flip vrender1 before fetch_go so the finished bank is read

`default_nettype none

`include "obj_consts.svh"

module obj_line_fetch
    import obj_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      fetch_go,
    input  wire [15:0]               line_data,
    output logic [`OBJ_LINE_AW-1:0]  line_addr,
    output logic                     obj_valid,
    output logic [15:0]              obj_x,
    output logic [15:0]              obj_code,
    output logic [3:0]               obj_vsub,
    output logic [4:0]               obj_pal,
    output logic                     obj_hflip,
    output logic                     obj_vflip,
    output logic                     fetch_done
);

    localparam int EW = `OBJ_LINE_AW - 2; // entry index width

    localparam logic [2:0] F_IDLE = 3'd0;
    localparam logic [2:0] F_S0   = 3'd1; // word 0 addressed
    localparam logic [2:0] F_S1   = 3'd2; // word 0 on line_data
    localparam logic [2:0] F_S2   = 3'd3; // code on line_data
    localparam logic [2:0] F_S3   = 3'd4; // x on line_data
    localparam logic [2:0] F_FIN  = 3'd5;

    logic [2:0] state;
    obj_attr_u  lo_attr;  // low byte of word 0 holds the attribute fields
    logic       last_entry;

    assign lo_attr.raw = {8'h00, line_data[7:0]};
    assign last_entry  = (line_addr[`OBJ_LINE_AW-1:2] == EW'(`OBJ_LINE_TILES - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= F_IDLE;
            line_addr  <= '0;
            obj_valid  <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            obj_valid  <= 1'b0;
            fetch_done <= 1'b0;
            case (state)
                F_IDLE: begin
                    if (fetch_go) begin
                        line_addr <= '0;
                        state     <= F_S0;
                    end
                end
                F_S0: begin
                    line_addr <= line_addr + 1'b1;
                    state     <= F_S1;
                end
                F_S1: begin
                    if (line_data == `OBJ_EMPTY) begin
                        fetch_done <= 1'b1; // rest of the bank is fill
                        state      <= F_IDLE;
                    end else begin
                        line_addr <= line_addr + 1'b1;
                        state     <= F_S2;
                    end
                end
                F_S2: state <= F_S3;
                F_S3: begin
                    obj_valid <= 1'b1;
                    if (last_entry) begin
                        state <= F_FIN;
                    end else begin
                        line_addr <= {line_addr[`OBJ_LINE_AW-1:2] + 1'b1, 2'd0};
                        state     <= F_S0; // overlaps the output cycle
                    end
                end
                F_FIN: begin
                    fetch_done <= 1'b1;
                    state      <= F_IDLE;
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // descriptor fields, loaded as the words stream in
    always_ff @(posedge clk) begin
        if (state == F_S1) begin
            obj_vsub  <= line_data[11:8];
            obj_pal   <= lo_attr.f.pal;
            obj_hflip <= lo_attr.f.hflip;
            obj_vflip <= lo_attr.f.vflip;
        end
        if (state == F_S2) begin
            obj_code <= line_data;
        end
        if (state == F_S3) begin
            obj_x <= line_data;
        end
    end

    a_valid_done: assert property (@(posedge clk) disable iff (rst)
        !(obj_valid && fetch_done))
        else $error("line fetch: descriptor and done in the same cycle");

endmodule

`default_nettype wire

/* obj_line_top.sv */
// object line layer, frame table plus line builder plus line fetch
// no back pressure, vrender1 steady during a build and flipped before a fetch

`default_nettype none

`include "obj_consts.svh"

module obj_line_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [`OBJ_FRAME_AW-1:0] wr_addr,
    input  wire [15:0]              wr_data,
    input  wire                     wr_en,
    input  wire [8:0]               vrender1,
    input  wire                     start,
    input  wire                     fetch_go,
    output wire                     build_done,
    output wire                     obj_valid,
    output wire [15:0]              obj_x,
    output wire [15:0]              obj_code,
    output wire [3:0]               obj_vsub,
    output wire [4:0]               obj_pal,
    output wire                     obj_hflip,
    output wire                     obj_vflip,
    output wire                     fetch_done
);

    wire [`OBJ_FRAME_AW-1:0] frame_addr;
    wire [15:0]              frame_data;
    wire [`OBJ_LINE_AW-1:0]  line_addr;
    wire [15:0]              line_data;

    obj_frame_ram u_frame (
        .clk     (clk),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_en   (wr_en),
        .rd_addr (frame_addr),
        .rd_data (frame_data)
    );

    obj_line_table u_table (
        .clk        (clk),
        .rst        (rst),
        .vrender1   (vrender1),
        .start      (start),
        .frame_addr (frame_addr),
        .frame_data (frame_data),
        .line_addr  (line_addr),
        .line_data  (line_data),
        .build_done (build_done)
    );

    obj_line_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .fetch_go   (fetch_go),
        .line_data  (line_data),
        .line_addr  (line_addr),
        .obj_valid  (obj_valid),
        .obj_x      (obj_x),
        .obj_code   (obj_code),
        .obj_vsub   (obj_vsub),
        .obj_pal    (obj_pal),
        .obj_hflip  (obj_hflip),
        .obj_vflip  (obj_vflip),
        .fetch_done (fetch_done)
    );

endmodule

`default_nettype wire

/* tb_obj_line.sv */
// testbench for the object line layer, run from the project root so obj_tests.txt is found
// the frame table is first filled with one-tile objects on lines 248 to 263
// test lines stay below 248 so the fill objects never show up in a line

`default_nettype none

module tb_obj_line;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BUILD_LIMIT = 2600; // full table walk plus 128 tiles
    localparam int FETCH_LIMIT = 600;  // 128 entries of four cycles

    logic        clk;
    logic        rst;
    logic [9:0]  wr_addr;
    logic [15:0] wr_data;
    logic        wr_en;
    logic [8:0]  vrender1;
    logic        start;
    logic        fetch_go;
    wire         build_done;
    wire         obj_valid;
    wire [15:0]  obj_x;
    wire [15:0]  obj_code;
    wire [3:0]   obj_vsub;
    wire [4:0]   obj_pal;
    wire         obj_hflip;
    wire         obj_vflip;
    wire         fetch_done;

    int          errors;
    int          checks;
    int          limit_cycles;
    logic [42:0] exp_q [$]; // {x, code, vsub, pal, hflip, vflip}

    // test file fields
    int             fd;
    int             n_fields;
    int             n_lines;
    int             n_writes;
    int             line_v;
    int             p_vsub;
    int             p_pal;
    int             p_h;
    int             p_v;
    int             p_cnt;
    logic [15:0]    a_hex;
    logic [15:0]    b_hex;
    reg [8*128-1:0] text;
    reg [7:0]       cmd;

    obj_line_top uut (
        .clk        (clk),
        .rst        (rst),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_en      (wr_en),
        .vrender1   (vrender1),
        .start      (start),
        .fetch_go   (fetch_go),
        .build_done (build_done),
        .obj_valid  (obj_valid),
        .obj_x      (obj_x),
        .obj_code   (obj_code),
        .obj_vsub   (obj_vsub),
        .obj_pal    (obj_pal),
        .obj_hflip  (obj_hflip),
        .obj_vflip  (obj_vflip),
        .fetch_done (fetch_done)
    );

    always #5 clk = ~clk;

    // attr low byte and y high byte carry the object index
    function automatic logic [15:0] fill_word(input logic [9:0] a);
        case (a[1:0])
            2'd3:    fill_word = {8'h00, a[9:2]}; // attr, single tile
            2'd1:    fill_word = {a[9:2], 8'hf8}; // y low byte 248
            default: fill_word = {6'd0, a};       // code and x
        endcase
    endfunction

    function automatic logic [42:0] pack_desc(input logic [15:0] x, input logic [15:0] code,
                                              input int vsub, input int pal,
                                              input int h, input int v);
        pack_desc = {x, code, 4'(vsub), 5'(pal), 1'(h), 1'(v)};
    endfunction

    function automatic string desc_text(input logic [42:0] d);
        desc_text = $sformatf("x=%h code=%h vsub=%0d pal=%0d hflip=%0b vflip=%0b",
                              d[42:27], d[26:11], d[10:7], d[6:2], d[1], d[0]);
    endfunction

    task automatic write_word(input logic [9:0] addr, input logic [15:0] data);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
    endtask

    task automatic check_field_count(input int got, input int want, input string what);
        checks++;
        assert (got == want)
            else begin
                $display("malformed %s line in obj_tests.txt", what);
                errors++;
            end
    endtask

    // outputs must stay quiet while nothing has been started
    task automatic fill_frame();
        for (int a = 0; a < 1024; a++) begin
            write_word(10'(a), fill_word(10'(a)));
            @(negedge clk);
            checks++;
            assert (!build_done && !obj_valid && !fetch_done)
                else begin
                    $display("** Error at %0t ns: output high before any start, addr %0d",
                             $time, a);
                    errors++;
                end
        end
    endtask

    task automatic count_commands();
        n_lines  = 0;
        n_writes = 0;
        fd = $fopen("obj_tests.txt", "r");
        if (fd != 0) begin
            text = '0;
            while ($fgets(text, fd) != 0) begin
                cmd = 8'h00;
                n_fields = $sscanf(text, "%s", cmd);
                if (cmd == "L") n_lines++;
                if (cmd == "W") n_writes++;
                text = '0;
            end
            $fclose(fd);
        end
    endtask

    // build line, flip vrender1, fetch and compare with the queued descriptors
    task automatic run_line(input int line);
        int          waited;
        int          tile;
        logic        done;
        logic [42:0] got;
        logic [42:0] want;
        @(posedge clk);
        wr_en    <= 1'b0;
        vrender1 <= 9'(line);
        start    <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        checks++;
        assert (!build_done)
            else begin
                $display("** Error at %0t ns: build_done not cleared by start", $time);
                errors++;
            end
        waited = 0;
        while (!build_done && waited < BUILD_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (build_done)
            else begin
                $display("build of line %0d never raised build_done", line);
                errors++;
            end
        @(posedge clk);
        vrender1 <= 9'(line + 1); // finished bank becomes readable
        fetch_go <= 1'b1;
        @(posedge clk);
        fetch_go <= 1'b0;
        tile   = 0;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < FETCH_LIMIT) begin
            @(negedge clk);
            waited++;
            if (obj_valid) begin
                got = {obj_x, obj_code, obj_vsub, obj_pal, obj_hflip, obj_vflip};
                checks++;
                assert (exp_q.size() > 0)
                    else begin
                        $display("** Error at %0t ns: line %0d extra tile %0d, %s",
                                 $time, line, tile, desc_text(got));
                        errors++;
                    end
                if (exp_q.size() > 0) begin
                    want = exp_q.pop_front();
                    assert (got == want)
                        else begin
                            $display("** Error at %0t ns: line %0d tile %0d got %s",
                                     $time, line, tile, desc_text(got));
                            $display("    expected %s", desc_text(want));
                            errors++;
                        end
                end
                tile++;
            end
            if (fetch_done) done = 1'b1;
        end
        checks++;
        assert (done)
            else begin
                $display("fetch of line %0d never raised fetch_done", line);
                errors++;
            end
        checks++;
        assert (exp_q.size() == 0)
            else begin
                $display("** Error at %0t ns: line %0d ended with %0d tiles missing",
                         $time, line, exp_q.size());
                errors++;
            end
    endtask

    task automatic run_tests_file();
        fd = $fopen("obj_tests.txt", "r");
        text = '0;
        while ($fgets(text, fd) != 0) begin
            cmd = 8'h00;
            n_fields = $sscanf(text, "%s", cmd);
            if (cmd == "W") begin
                n_fields = $sscanf(text, "%s %h %h", cmd, a_hex, b_hex);
                check_field_count(n_fields, 3, "W");
                write_word(a_hex[9:0], b_hex);
            end else if (cmd == "L") begin
                n_fields = $sscanf(text, "%s %d", cmd, line_v);
                check_field_count(n_fields, 2, "L");
                exp_q.delete();
            end else if (cmd == "E") begin
                n_fields = $sscanf(text, "%s %h %h %d %d %d %d", cmd, a_hex, b_hex,
                                   p_vsub, p_pal, p_h, p_v);
                check_field_count(n_fields, 7, "E");
                exp_q.push_back(pack_desc(a_hex, b_hex, p_vsub, p_pal, p_h, p_v));
            end else if (cmd == "S") begin
                n_fields = $sscanf(text, "%s %h %h %d %d %d %d %d", cmd, a_hex, b_hex,
                                   p_vsub, p_pal, p_h, p_v, p_cnt);
                check_field_count(n_fields, 8, "S");
                for (int k = 0; k < p_cnt; k++) begin // one column per step
                    exp_q.push_back(pack_desc(a_hex + 16'(16 * k), b_hex + 16'(k),
                                              p_vsub, p_pal, p_h, p_v));
                end
            end else if (cmd == "F") begin
                run_line(line_v);
            end else begin
                checks++;
                assert (cmd == "#" || cmd == 8'h00)
                    else begin
                        $display("unknown command %s in obj_tests.txt", cmd);
                        errors++;
                    end
            end
            text = '0;
        end
        $fclose(fd);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        wr_addr      = '0;
        wr_data      = '0;
        wr_en        = 1'b0;
        vrender1     = '0;
        start        = 1'b0;
        fetch_go     = 1'b0;
        errors       = 0;
        checks       = 0;
        limit_cycles = 0;
        count_commands();
        if (fd == 0) begin
            $display("cannot open obj_tests.txt, no tests were run");
            errors++;
        end else begin
            limit_cycles = 1200 + 2 * n_writes + 2000 * n_lines;
            repeat (4) @(posedge clk);
            rst <= 1'b0;
            fill_frame();
            run_tests_file();
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // limit scales with the number of writes and line commands
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("run did not finish within %0d cycles, stopped by the watchdog", limit_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* obj_tests.txt */
# W addr data in hex | L line in decimal | F runs the line and expects fetch_done
# E x code in hex, vsub pal hflip vflip in decimal | S as E plus a count, x +16 and code +1 per step
# single one-tile object
W 3ff 0003
W 3fe 0120
W 3fd 0020
W 3fc 0050
L 37
E 0050 0120 5 3 0 0
F
# three columns, then three columns under hflip
W 3ff 0204
W 3fe 0300
W 3fd 0040
W 3fc 0010
W 3fb 0225
W 3fa 0400
W 3f9 0040
W 3f8 0080
L 70
E 0010 0300 6 4 0 0
E 0020 0301 6 4 0 0
E 0030 0302 6 4 0 0
E 00a0 0400 6 5 1 0
E 0090 0401 6 5 1 0
E 0080 0402 6 5 1 0
F
# two rows tall, second row, then the same under vflip
W 3ff 1006
W 3fe 0500
W 3fd 0060
W 3fc 0030
W 3fb 1047
W 3fa 0600
W 3f9 0060
W 3f8 0070
L 115
E 0030 0510 3 6 0 0
E 0070 0600 12 7 0 1
F
# exact repeat and an object off the line give nothing
W 3ff 0008
W 3fe 0700
W 3fd 0080
W 3fc 0040
W 3fb 0008
W 3fa 0700
W 3f9 0080
W 3f8 0040
W 3f7 0009
W 3f6 0800
W 3f5 00a0
W 3f4 0060
L 130
E 0040 0700 2 8 0 0
F
# nine 16-column objects, line stops at 128 tiles
W 3ff 0f01
W 3fe 1000
W 3fd 00c0
W 3fc 0000
W 3fb 0f01
W 3fa 1100
W 3f9 00c0
W 3f8 0000
W 3f7 0f01
W 3f6 1200
W 3f5 00c0
W 3f4 0000
W 3f3 0f01
W 3f2 1300
W 3f1 00c0
W 3f0 0000
W 3ef 0f01
W 3ee 1400
W 3ed 00c0
W 3ec 0000
W 3eb 0f01
W 3ea 1500
W 3e9 00c0
W 3e8 0000
W 3e7 0f01
W 3e6 1600
W 3e5 00c0
W 3e4 0000
W 3e3 0f01
W 3e2 1700
W 3e1 00c0
W 3e0 0000
W 3df 0f01
W 3de 1800
W 3dd 00c0
W 3dc 0000
L 200
S 0000 1000 8 1 0 0 16
S 0000 1100 8 1 0 0 16
S 0000 1200 8 1 0 0 16
S 0000 1300 8 1 0 0 16
S 0000 1400 8 1 0 0 16
S 0000 1500 8 1 0 0 16
S 0000 1600 8 1 0 0 16
S 0000 1700 8 1 0 0 16
F

/* files.f */
+incdir+.
obj_pkg.sv
obj_frame_ram.sv
obj_zone_match.sv
obj_line_table.sv
obj_line_fetch.sv
obj_line_top.sv
tb_obj_line.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_obj_line -o tb_obj_line_sim

status=0
./obj_dir/tb_obj_line_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TEST RESULT: PASS" sim.log; then
    exit 1
fi
